//--- include/rdma_defs.svh
//////////////////////////////////////////////////////////////////////
// RDMA request path parameters
// Field widths, path MTU and queue depths shared by all blocks
//////////////////////////////////////////////////////////////////////

`ifndef RDMA_DEFS_SVH
`define RDMA_DEFS_SVH

// Field widths
`define RDMA_VADDR_BITS   48  // Virtual address
`define RDMA_LEN_BITS     32  // Byte length
`define RDMA_QPN_BITS     10  // Queue pair number
`define RDMA_PARAMS_BITS  64  // Opaque parameters

// Segmentation
`define RDMA_PMTU_BYTES   1024

// Buffering
`define RDMA_QUEUE_DEPTH  16  // Input and output request queues
`define RDMA_ORDER_DEPTH  4   // Parser route record

`endif

//--- hdl/rdma_cmd_pkg.sv
//////////////////////////////////////////////////////////////////////
// RDMA application command types
// Opcodes, mode encoding and the command struct seen by the host
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "rdma_defs.svh"

package rdma_cmd_pkg;

  // Application opcodes, anything else is unknown
  typedef enum logic [4:0] {
    APP_READ  = 5'h00,
    APP_WRITE = 5'h01,
    APP_SEND  = 5'h02,
    APP_IMMED = 5'h03
  } app_opcode_t;

  // Mode bit
  localparam logic RDMA_MODE_PARSE = 1'b0;  // Opcode interpreted
  localparam logic RDMA_MODE_RAW   = 1'b1;  // Opcode passed as is

  // Command as issued by the application
  typedef struct packed {
    app_opcode_t                   opcode;
    logic [`RDMA_QPN_BITS-1:0]     qpn;
    logic                          mode;
    logic [`RDMA_VADDR_BITS-1:0]   lvaddr;  // Local buffer
    logic [`RDMA_VADDR_BITS-1:0]   rvaddr;  // Remote buffer
    logic [`RDMA_LEN_BITS-1:0]     len;     // Bytes
    logic [`RDMA_PARAMS_BITS-1:0]  params;
  } rdma_cmd_t;

endpackage

`default_nettype wire

//--- hdl/rdma_pkt_pkg.sv
//////////////////////////////////////////////////////////////////////
// RDMA wire side packet request types
// Reliable connection opcodes and the per packet request struct
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "rdma_defs.svh"

package rdma_pkt_pkg;

  // RC opcodes as on the wire
  typedef enum logic [4:0] {
    RC_SEND_ONLY          = 5'h04,
    RC_RDMA_WRITE_FIRST   = 5'h06,
    RC_RDMA_WRITE_MIDDLE  = 5'h07,
    RC_RDMA_WRITE_LAST    = 5'h08,
    RC_RDMA_WRITE_ONLY    = 5'h0A,
    RC_RDMA_READ_REQUEST  = 5'h0C
  } rc_opcode_t;

  // One packet request towards the packet builder
  typedef struct packed {
    rc_opcode_t                    opcode;  // Raw opcode in raw mode
    logic [`RDMA_QPN_BITS-1:0]     qpn;
    logic                          host;    // Payload from host memory
    logic                          mode;
    logic [`RDMA_VADDR_BITS-1:0]   lvaddr;
    logic [`RDMA_VADDR_BITS-1:0]   rvaddr;
    logic [`RDMA_LEN_BITS-1:0]     len;
    logic [`RDMA_PARAMS_BITS-1:0]  params;
  } rdma_pkt_req_t;

endpackage

`default_nettype wire

//--- hdl/rdma_req_queue.sv
//////////////////////////////////////////////////////////////////////
// Request queue
// Synchronous FIFO with valid/ready on both sides and a used count
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "rdma_defs.svh"

module rdma_req_queue #(
  parameter type T = rdma_cmd_pkg::rdma_cmd_t
) (
  input  logic        aclk,
  input  logic        aresetn,

  input  logic        s_valid,
  output logic        s_ready,
  input  T            s_data,

  output logic        m_valid,
  input  logic        m_ready,
  output T            m_data,

  output logic [31:0] used
);

  localparam int DEPTH = `RDMA_QUEUE_DEPTH;
  localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  T                mem [DEPTH];  // Storage
  logic [AW-1:0]   wr_ptr;
  logic [AW-1:0]   rd_ptr;
  logic [AW:0]     count;        // Occupancy
  logic            wr_en;
  logic            rd_en;

  assign s_ready = (count != DEPTH[AW:0]);  // Full stalls the writer
  assign m_valid = (count != '0);
  assign m_data  = mem[rd_ptr];
  assign used    = 32'(count);

  assign wr_en = s_valid && s_ready;
  assign rd_en = m_valid && m_ready;

  // Pointers and count
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en)
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (rd_en)
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (wr_en && !rd_en)
        count <= count + 1'b1;
      else if (rd_en && !wr_en)
        count <= count - 1'b1;
    end
  end

  // Payload, no reset
  always_ff @(posedge aclk) begin
    if (wr_en)
      mem[wr_ptr] <= s_data;
  end

  // A write never lands on an entry still waiting to be read
  a_no_write_full: assert property (@(posedge aclk) disable iff (!aresetn)
    wr_en && (count != '0) |-> (wr_ptr != rd_ptr));

endmodule

`default_nettype wire

//--- hdl/rdma_write_segmenter.sv
//////////////////////////////////////////////////////////////////////
// RDMA write segmenter
// Cuts one write command into packet requests of at most one path MTU
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "rdma_defs.svh"

module rdma_write_segmenter (
  input  logic                         aclk,
  input  logic                         aresetn,

  input  logic                         s_valid,
  output logic                         s_ready,
  input  rdma_cmd_pkg::rdma_cmd_t      s_cmd,

  output logic                         m_valid,
  input  logic                         m_ready,
  output rdma_pkt_pkg::rdma_pkt_req_t  m_pkt
);

  import rdma_cmd_pkg::*;
  import rdma_pkt_pkg::*;

  localparam logic [`RDMA_LEN_BITS-1:0]   PMTU_LEN = `RDMA_PMTU_BYTES;
  localparam logic [`RDMA_VADDR_BITS-1:0] PMTU_VA  = `RDMA_PMTU_BYTES;

  // FSM, one calc cycle in front of every segment
  typedef enum logic [1:0] {ST_IDLE, ST_CALC, ST_SEND} state_t;

  state_t                      state;
  rdma_cmd_t                   cmd_q;      // len and addresses walk along
  logic                        first_seg;
  logic                        more_seg;
  logic [`RDMA_LEN_BITS-1:0]   seg_len;
  rdma_pkt_req_t               pkt_q;

  assign more_seg = (cmd_q.len > PMTU_LEN);          // Not the final one
  assign seg_len  = more_seg ? PMTU_LEN : cmd_q.len;

  assign s_ready = (state == ST_IDLE);
  assign m_valid = (state == ST_SEND);
  assign m_pkt   = pkt_q;

  //////////////////////////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: if (s_valid) state <= ST_CALC;
        ST_CALC: state <= ST_SEND;
        ST_SEND: if (m_ready) state <= (cmd_q.len == '0) ? ST_IDLE : ST_CALC;  // Nothing left
        default: state <= ST_IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (s_valid && s_ready) begin
      cmd_q     <= s_cmd;
      first_seg <= 1'b1;
    end

    if (state == ST_CALC) begin
      // Opcode by position in the message
      if (more_seg)
        pkt_q.opcode <= first_seg ? RC_RDMA_WRITE_FIRST : RC_RDMA_WRITE_MIDDLE;
      else
        pkt_q.opcode <= first_seg ? RC_RDMA_WRITE_ONLY : RC_RDMA_WRITE_LAST;
      pkt_q.qpn    <= cmd_q.qpn;
      pkt_q.host   <= 1'b1;
      pkt_q.mode   <= cmd_q.mode;
      pkt_q.lvaddr <= cmd_q.lvaddr;
      pkt_q.rvaddr <= cmd_q.rvaddr;
      pkt_q.len    <= seg_len;
      pkt_q.params <= cmd_q.params;

      // Advance to next segment
      cmd_q.len    <= cmd_q.len - seg_len;   // Reaches zero on the final one
      cmd_q.lvaddr <= cmd_q.lvaddr + PMTU_VA;
      cmd_q.rvaddr <= cmd_q.rvaddr + PMTU_VA;
      first_seg    <= 1'b0;
    end
  end

  // Emitted segment never larger than the path MTU
  a_seg_len_mtu: assert property (@(posedge aclk) disable iff (!aresetn)
    m_valid |-> (m_pkt.len <= PMTU_LEN));

endmodule

`default_nettype wire

//--- hdl/rdma_single_former.sv
//////////////////////////////////////////////////////////////////////
// Single packet former
// One packet request per read, send, immediate or raw command
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module rdma_single_former (
  input  logic                         aclk,
  input  logic                         aresetn,

  input  logic                         s_valid,
  output logic                         s_ready,
  input  rdma_cmd_pkg::rdma_cmd_t      s_cmd,

  output logic                         m_valid,
  input  logic                         m_ready,
  output rdma_pkt_pkg::rdma_pkt_req_t  m_pkt
);

  import rdma_cmd_pkg::*;
  import rdma_pkt_pkg::*;

  logic           valid_q;
  rdma_pkt_req_t  pkt_q;   // Output register

  assign s_ready = !valid_q || m_ready;  // Refill on the take edge
  assign m_valid = valid_q;
  assign m_pkt   = pkt_q;

  always_ff @(posedge aclk) begin
    if (!aresetn)
      valid_q <= 1'b0;
    else if (s_ready)
      valid_q <= s_valid;
  end

  always_ff @(posedge aclk) begin
    if (s_valid && s_ready) begin
      if (s_cmd.mode == RDMA_MODE_RAW)
        pkt_q.opcode <= rc_opcode_t'(s_cmd.opcode);     // Untouched
      else if (s_cmd.opcode == APP_READ)
        pkt_q.opcode <= RC_RDMA_READ_REQUEST;
      else
        pkt_q.opcode <= RC_SEND_ONLY;                   // Send and immediate
      pkt_q.host   <= !((s_cmd.mode == RDMA_MODE_PARSE) && (s_cmd.opcode == APP_IMMED));
      pkt_q.qpn    <= s_cmd.qpn;
      pkt_q.mode   <= s_cmd.mode;
      pkt_q.lvaddr <= s_cmd.lvaddr;
      pkt_q.rvaddr <= s_cmd.rvaddr;
      pkt_q.len    <= s_cmd.len;
      pkt_q.params <= s_cmd.params;
    end
  end

endmodule

`default_nettype wire

//--- hdl/rdma_req_parser.sv
//////////////////////////////////////////////////////////////////////
// RDMA request parser
// Steers commands to the two engines and merges their packets back
// into command order through a small route record
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "rdma_defs.svh"

module rdma_req_parser (
  input  logic                         aclk,
  input  logic                         aresetn,
  // Commands in
  input  logic                         s_valid,
  output logic                         s_ready,
  input  rdma_cmd_pkg::rdma_cmd_t      s_cmd,
  // To engines
  output logic                         wr_valid,
  input  logic                         wr_ready,
  output rdma_cmd_pkg::rdma_cmd_t      wr_cmd,
  output logic                         one_valid,
  input  logic                         one_ready,
  output rdma_cmd_pkg::rdma_cmd_t      one_cmd,
  // From engines
  input  logic                         wr_pkt_valid,
  output logic                         wr_pkt_ready,
  input  rdma_pkt_pkg::rdma_pkt_req_t  wr_pkt,
  input  logic                         one_pkt_valid,
  output logic                         one_pkt_ready,
  input  rdma_pkt_pkg::rdma_pkt_req_t  one_pkt,
  // Merged packets out
  output logic                         m_valid,
  input  logic                         m_ready,
  output rdma_pkt_pkg::rdma_pkt_req_t  m_pkt
);

  import rdma_cmd_pkg::*;
  import rdma_pkt_pkg::*;

  localparam int DEPTH = `RDMA_ORDER_DEPTH;
  localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic             is_wr, is_one, is_drop;
  logic [DEPTH-1:0] route_q;          // 1 = segmenter
  logic [AW-1:0]    ord_wr_ptr, ord_rd_ptr;
  logic [AW:0]      ord_cnt;
  logic             ord_full, ord_empty;
  logic             head_wr;
  logic             push, pop;

  //////////////////////////////////////////////////////////////////////
  // Steering
  //////////////////////////////////////////////////////////////////////
  assign is_wr   = (s_cmd.mode == RDMA_MODE_PARSE) && (s_cmd.opcode == APP_WRITE);
  assign is_one  = (s_cmd.mode == RDMA_MODE_RAW) ||
                   (s_cmd.opcode inside {APP_READ, APP_SEND, APP_IMMED});
  assign is_drop = !is_wr && !is_one;  // Unknown parse opcode

  assign wr_valid  = s_valid && is_wr && !ord_full;
  assign one_valid = s_valid && is_one && !ord_full;
  assign wr_cmd    = s_cmd;
  assign one_cmd   = s_cmd;

  assign s_ready = is_drop || (!ord_full && (is_wr ? wr_ready : one_ready));
  assign push    = s_valid && s_ready && !is_drop;

  //////////////////////////////////////////////////////////////////////
  // Merge, head of the record picks the engine
  //////////////////////////////////////////////////////////////////////
  assign head_wr       = route_q[ord_rd_ptr];
  assign m_valid       = !ord_empty && (head_wr ? wr_pkt_valid : one_pkt_valid);
  assign m_pkt         = head_wr ? wr_pkt : one_pkt;
  assign wr_pkt_ready  = !ord_empty && head_wr && m_ready;
  assign one_pkt_ready = !ord_empty && !head_wr && m_ready;

  // Segmenter command ends on LAST or ONLY, former on every packet
  assign pop = m_valid && m_ready &&
               (!head_wr || (m_pkt.opcode inside {RC_RDMA_WRITE_LAST, RC_RDMA_WRITE_ONLY}));

  // Route record
  assign ord_full  = (ord_cnt == DEPTH[AW:0]);
  assign ord_empty = (ord_cnt == '0);

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      ord_wr_ptr <= '0;
      ord_rd_ptr <= '0;
      ord_cnt    <= '0;
    end else begin
      if (push)
        ord_wr_ptr <= (ord_wr_ptr == AW'(DEPTH - 1)) ? '0 : ord_wr_ptr + 1'b1;
      if (pop)
        ord_rd_ptr <= (ord_rd_ptr == AW'(DEPTH - 1)) ? '0 : ord_rd_ptr + 1'b1;
      if (push && !pop)
        ord_cnt <= ord_cnt + 1'b1;
      else if (pop && !push)
        ord_cnt <= ord_cnt - 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (push)
      route_q[ord_wr_ptr] <= is_wr;
  end

  // Record pointers meet only when empty or full
  a_no_push_full: assert property (@(posedge aclk) disable iff (!aresetn)
    push && !ord_empty |-> (ord_wr_ptr != ord_rd_ptr));
  a_no_pop_empty: assert property (@(posedge aclk) disable iff (!aresetn)
    pop |-> ord_full || (ord_wr_ptr != ord_rd_ptr));

endmodule

`default_nettype wire

//--- hdl/rdma_req_top.sv
//////////////////////////////////////////////////////////////////////
// RDMA request path top
// Input queue, parser with write segmenter and single former,
// output queue
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module rdma_req_top (
  input  logic                         aclk,
  input  logic                         aresetn,

  input  logic                         s_cmd_valid,
  output logic                         s_cmd_ready,
  input  rdma_cmd_pkg::rdma_cmd_t      s_cmd,

  output logic                         m_pkt_valid,
  input  logic                         m_pkt_ready,
  output rdma_pkt_pkg::rdma_pkt_req_t  m_pkt,

  output logic [31:0]                  used
);

  import rdma_cmd_pkg::*;
  import rdma_pkt_pkg::*;

  // Queued commands to parser
  logic           cmd_valid, cmd_ready;
  rdma_cmd_t      cmd;
  // Parser to engines
  logic           wr_valid, wr_ready, one_valid, one_ready;
  rdma_cmd_t      wr_cmd, one_cmd;
  // Engines back to parser
  logic           wr_pkt_valid, wr_pkt_ready, one_pkt_valid, one_pkt_ready;
  rdma_pkt_req_t  wr_pkt, one_pkt;
  // Merged packets to output queue
  logic           pkt_valid, pkt_ready;
  rdma_pkt_req_t  pkt;

  rdma_req_queue #(.T(rdma_cmd_t)) cmd_queue_inst (
    .aclk, .aresetn,
    .s_valid(s_cmd_valid), .s_ready(s_cmd_ready), .s_data(s_cmd),
    .m_valid(cmd_valid),   .m_ready(cmd_ready),   .m_data(cmd),
    .used
  );

  rdma_req_parser parser_inst (
    .aclk, .aresetn,
    .s_valid(cmd_valid), .s_ready(cmd_ready), .s_cmd(cmd),
    .wr_valid, .wr_ready, .wr_cmd,
    .one_valid, .one_ready, .one_cmd,
    .wr_pkt_valid, .wr_pkt_ready, .wr_pkt,
    .one_pkt_valid, .one_pkt_ready, .one_pkt,
    .m_valid(pkt_valid), .m_ready(pkt_ready), .m_pkt(pkt)
  );

  rdma_write_segmenter segmenter_inst (
    .aclk, .aresetn,
    .s_valid(wr_valid),     .s_ready(wr_ready),     .s_cmd(wr_cmd),
    .m_valid(wr_pkt_valid), .m_ready(wr_pkt_ready), .m_pkt(wr_pkt)
  );

  rdma_single_former former_inst (
    .aclk, .aresetn,
    .s_valid(one_valid),     .s_ready(one_ready),     .s_cmd(one_cmd),
    .m_valid(one_pkt_valid), .m_ready(one_pkt_ready), .m_pkt(one_pkt)
  );

  // Output decoupling, occupancy not exported
  rdma_req_queue #(.T(rdma_pkt_req_t)) pkt_queue_inst (
    .aclk, .aresetn,
    .s_valid(pkt_valid),   .s_ready(pkt_ready),   .s_data(pkt),
    .m_valid(m_pkt_valid), .m_ready(m_pkt_ready), .m_data(m_pkt),
    .used()
  );

endmodule

`default_nettype wire

//--- test/rdma_req_checker.sv
//////////////////////////////////////////////////////////////////////
// RDMA request path monitor
// Predicts packet requests from accepted commands, compares them
// against the packets leaving the DUT and bounds the used count
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "rdma_defs.svh"

module rdma_req_checker (
  input  logic                         aclk,
  input  logic                         aresetn,
  input  logic                         s_cmd_valid,
  input  logic                         s_cmd_ready,
  input  rdma_cmd_pkg::rdma_cmd_t      s_cmd,
  input  string                        test_name,   // Name of the command on s_cmd
  input  logic                         m_pkt_valid,
  input  logic                         m_pkt_ready,
  input  rdma_pkt_pkg::rdma_pkt_req_t  m_pkt,
  input  logic [31:0]                  used,
  output int                           err_cnt,
  output int                           pending,     // Predicted, not yet seen
  output int                           got_cnt
);

  import rdma_cmd_pkg::*;
  import rdma_pkt_pkg::*;

  localparam logic [`RDMA_LEN_BITS-1:0] PMTU = `RDMA_PMTU_BYTES;

  rdma_pkt_req_t exp_q [$];   // Expected packets in command order
  string         name_q [$];  // Source command of each

  task automatic push_exp(input rdma_pkt_req_t p, input string nm);
    exp_q.push_back(p);
    name_q.push_back(nm);
  endtask

  // Expand one command into its packets
  task automatic predict(input rdma_cmd_t c, input string nm);
    rdma_pkt_req_t             p;
    logic [4:0]                raw_op;
    logic [`RDMA_LEN_BITS-1:0] left;
    bit                        first;
    raw_op   = c.opcode;
    p.opcode = RC_SEND_ONLY;
    p.qpn    = c.qpn;
    p.host   = 1'b1;
    p.mode   = c.mode;
    p.lvaddr = c.lvaddr;
    p.rvaddr = c.rvaddr;
    p.len    = c.len;
    p.params = c.params;
    if (c.mode == RDMA_MODE_RAW) begin
      p.opcode = rc_opcode_t'(raw_op);  // Passed through
      push_exp(p, nm);
    end else begin
      case (c.opcode)
        APP_READ: begin
          p.opcode = RC_RDMA_READ_REQUEST;
          push_exp(p, nm);
        end
        APP_SEND:  push_exp(p, nm);
        APP_IMMED: begin
          p.host = 1'b0;                 // Immediate carries no host payload
          push_exp(p, nm);
        end
        APP_WRITE: begin
          left  = c.len;
          first = 1'b1;
          while (left > PMTU) begin      // Full MTU segments
            if (first)
              p.opcode = RC_RDMA_WRITE_FIRST;
            else
              p.opcode = RC_RDMA_WRITE_MIDDLE;
            p.len = PMTU;
            push_exp(p, nm);
            p.lvaddr = p.lvaddr + `RDMA_PMTU_BYTES;
            p.rvaddr = p.rvaddr + `RDMA_PMTU_BYTES;
            left     = left - PMTU;
            first    = 1'b0;
          end
          if (first)
            p.opcode = RC_RDMA_WRITE_ONLY;   // Zero length lands here too
          else
            p.opcode = RC_RDMA_WRITE_LAST;
          p.len = left;
          push_exp(p, nm);
        end
        default: ;                       // Unknown, no packet
      endcase
    end
  endtask

  initial begin
    err_cnt = 0;
    pending = 0;
    got_cnt = 0;
  end

  // DUT settles after the rising edge, look at mid cycle
  always @(negedge aclk) begin : watch
    rdma_pkt_req_t exp_pkt;
    string         nm;
    if (aresetn) begin
      if (m_pkt_valid && m_pkt_ready) begin
        got_cnt++;
        if (exp_q.size() == 0) begin
          $display("Packet with opcode %h arrived with no command pending", m_pkt.opcode);
          err_cnt++;
        end else begin
          exp_pkt = exp_q.pop_front();
          nm      = name_q.pop_front();
          if (m_pkt !== exp_pkt) begin
            $display("ERR %s exp %h act %h", nm, exp_pkt, m_pkt);
            err_cnt++;
          end
        end
      end
      if (s_cmd_valid && s_cmd_ready)
        predict(s_cmd, test_name);
      if (used > `RDMA_QUEUE_DEPTH) begin        // Occupancy bound
        $display("ERR used_bound exp <= %0d act %0d", `RDMA_QUEUE_DEPTH, used);
        err_cnt++;
      end
      pending = exp_q.size();
    end
  end

endmodule

`default_nettype wire

//--- test/rdma_req_tb.sv
//////////////////////////////////////////////////////////////////////
// RDMA request path testbench
// Applies a named command table under random back-pressure, then
// stalls the output to fill the queues and drains everything
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "rdma_defs.svh"

module rdma_req_tb;

  import rdma_cmd_pkg::*;
  import rdma_pkt_pkg::*;

  localparam int NUM_STIM  = 18;
  localparam int MIX_START = 11;  // Mixed series, reused for the stall phase
  localparam int MIX_LEN   = 7;

  typedef struct {
    string     name;
    rdma_cmd_t cmd;
    int        exp_pkts;          // Packets this command must produce
  } stim_t;

  logic          aclk;
  logic          aresetn;
  logic          s_cmd_valid;
  logic          s_cmd_ready;
  rdma_cmd_t     s_cmd;
  logic          m_pkt_valid;
  logic          m_pkt_ready;
  rdma_pkt_req_t m_pkt;
  logic [31:0]   used;

  string cur_name;
  int    err_cnt, pending, got_cnt;   // From the checker
  stim_t stim [NUM_STIM];
  bit    hold_low;                    // Force m_pkt_ready low
  bit    aborted;
  int    exp_total, tb_err, timeouts;

  rdma_req_top rdma_req_top_inst (
    .aclk, .aresetn,
    .s_cmd_valid, .s_cmd_ready, .s_cmd,
    .m_pkt_valid, .m_pkt_ready, .m_pkt,
    .used
  );

  rdma_req_checker rdma_req_checker_inst (
    .aclk, .aresetn,
    .s_cmd_valid, .s_cmd_ready, .s_cmd,
    .test_name(cur_name),
    .m_pkt_valid, .m_pkt_ready, .m_pkt,
    .used,
    .err_cnt, .pending, .got_cnt
  );

  initial aclk = 1'b0;
  always #10 aclk = ~aclk;  // 20 ns period

  function automatic stim_t make_stim(input string nm, input logic [4:0] op, input logic md,
                                      input logic [`RDMA_VADDR_BITS-1:0] lva,
                                      input logic [`RDMA_VADDR_BITS-1:0] rva,
                                      input logic [`RDMA_LEN_BITS-1:0] len, input int pkts);
    stim_t s;
    s.name       = nm;
    s.cmd.opcode = app_opcode_t'(op);
    s.cmd.qpn    = `RDMA_QPN_BITS'(len ^ 32'h2A5);  // Varies per entry
    s.cmd.mode   = md;
    s.cmd.lvaddr = lva;
    s.cmd.rvaddr = rva;
    s.cmd.len    = len;
    s.cmd.params = {lva[31:0], rva[31:0]} ^ 64'h5A5A_0F0F_C3C3_1234;
    s.exp_pkts   = pkts;
    return s;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Stimulus table
  //////////////////////////////////////////////////////////////////////
  task automatic build_table();
    stim[0]  = make_stim("rd_parse",    APP_READ,  RDMA_MODE_PARSE, 48'h1000_0000, 48'h2_0000_0040, 256, 1);
    stim[1]  = make_stim("send_parse",  APP_SEND,  RDMA_MODE_PARSE, 48'h1000_4000, 48'h2_0000_1000, 64, 1);
    stim[2]  = make_stim("immed_parse", APP_IMMED, RDMA_MODE_PARSE, 48'h1000_8000, 48'h2_0000_2000, 16, 1);
    stim[3]  = make_stim("wr_len0",     APP_WRITE, RDMA_MODE_PARSE, 48'h3000_0000, 48'h4_0000_0000, 0, 1);
    stim[4]  = make_stim("wr_len1024",  APP_WRITE, RDMA_MODE_PARSE, 48'h3000_1000, 48'h4_0000_8000, 1024, 1);
    stim[5]  = make_stim("wr_len700",   APP_WRITE, RDMA_MODE_PARSE, 48'h3000_2000, 48'h4_0001_0000, 700, 1);
    stim[6]  = make_stim("wr_len2500",  APP_WRITE, RDMA_MODE_PARSE, 48'h3001_0000, 48'h4_0002_0000, 2500, 3);
    stim[7]  = make_stim("wr_len3072",  APP_WRITE, RDMA_MODE_PARSE, 48'h3002_0000, 48'h4_0003_0000, 3072, 3);
    stim[8]  = make_stim("raw_cmd",     5'h11,     RDMA_MODE_RAW,   48'h5000_0010, 48'h6_0000_0020, 77, 1);
    stim[9]  = make_stim("raw_write",   APP_WRITE, RDMA_MODE_RAW,   48'h5000_1000, 48'h6_0000_1000, 5000, 1);
    stim[10] = make_stim("unknown_op",  5'h1F,     RDMA_MODE_PARSE, 48'h5000_2000, 48'h6_0000_2000, 512, 0);
    stim[11] = make_stim("mix_wr1500",  APP_WRITE, RDMA_MODE_PARSE, 48'h7000_0000, 48'h8_0000_0000, 1500, 2);
    stim[12] = make_stim("mix_rd128",   APP_READ,  RDMA_MODE_PARSE, 48'h7000_4000, 48'h8_0000_4000, 128, 1);
    stim[13] = make_stim("mix_wr4096",  APP_WRITE, RDMA_MODE_PARSE, 48'h7001_0000, 48'h8_0001_0000, 4096, 4);
    stim[14] = make_stim("mix_send32",  APP_SEND,  RDMA_MODE_PARSE, 48'h7002_0000, 48'h8_0002_0000, 32, 1);
    stim[15] = make_stim("mix_rd64",    APP_READ,  RDMA_MODE_PARSE, 48'h7003_0000, 48'h8_0003_0000, 64, 1);
    stim[16] = make_stim("mix_wr900",   APP_WRITE, RDMA_MODE_PARSE, 48'h7004_0000, 48'h8_0004_0000, 900, 1);
    stim[17] = make_stim("mix_immed8",  APP_IMMED, RDMA_MODE_PARSE, 48'h7005_0000, 48'h8_0005_0000, 8, 1);
  endtask

  // Raise valid and hold it until the transfer or the limit
  task automatic offer_cmd(input int idx, input int limit, output bit taken);
    int n;
    n        = 0;
    taken    = 1'b0;
    s_cmd    = stim[idx].cmd;
    cur_name = stim[idx].name;
    s_cmd_valid = 1'b1;
    while (!taken && n < limit) begin
      @(negedge aclk);
      taken = s_cmd_ready;  // Transfer on the coming edge
      @(posedge aclk);
      #1;
      n++;
    end
    if (taken)
      s_cmd_valid = 1'b0;   // Left high on a timeout
  endtask

  // Output held low until the input queue refuses commands
  task automatic stall_fill();
    int k;
    int idx;
    bit taken;
    bit stalled;
    stalled  = 1'b0;
    idx      = MIX_START;
    hold_low = 1'b1;
    for (k = 0; k < 64 && !stalled; k++) begin
      idx = MIX_START + (k % MIX_LEN);
      offer_cmd(idx, 20, taken);
      if (taken)
        exp_total += stim[idx].exp_pkts;
      else
        stalled = 1'b1;
    end
    if (!stalled) begin
      $display("Command input kept accepting with the packet output held low");
      tb_err++;
    end else begin
      @(negedge aclk);
      if (used !== `RDMA_QUEUE_DEPTH) begin
        $display("ERR stall_fill exp %0d act %0d", `RDMA_QUEUE_DEPTH, used);
        tb_err++;
      end
      @(posedge aclk);
      #1;
      hold_low = 1'b0;
      offer_cmd(idx, 400, taken);  // Same command, still pending
      if (taken) begin
        exp_total += stim[idx].exp_pkts;
      end else begin
        $display("Timeout: pending command not accepted after the output was released");
        timeouts++;
        aborted = 1'b1;
      end
    end
  endtask

  // Random back-pressure on the packet output
  initial begin : backpressure
    void'($urandom(73));
    m_pkt_ready = 1'b0;
    forever begin
      @(posedge aclk);
      #1;
      m_pkt_ready = hold_low ? 1'b0 : (($urandom % 4) != 0);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////
  initial begin : main
    int i;
    int n;
    bit taken;
    aresetn     = 1'b0;
    s_cmd_valid = 1'b0;
    s_cmd       = '0;
    cur_name    = "reset";
    hold_low    = 1'b0;
    aborted     = 1'b0;
    exp_total   = 0;
    tb_err      = 0;
    timeouts    = 0;
    build_table();
    repeat (4) @(posedge aclk);  // Reset for 4 cycles
    #1;
    aresetn = 1'b1;

    for (i = 0; i < NUM_STIM; i++) begin
      if (!aborted) begin
        offer_cmd(i, 200, taken);
        if (taken) begin
          exp_total += stim[i].exp_pkts;
        end else begin
          $display("Timeout: command %s was never accepted", stim[i].name);
          timeouts++;
          aborted = 1'b1;
        end
      end
    end

    if (!aborted)
      stall_fill();

    // Drain, checker updates mid cycle so look on the rising edge
    if (!aborted) begin
      n = 0;
      while (!(pending == 0 && got_cnt >= exp_total) && n < 3000) begin
        @(posedge aclk);
        n++;
      end
      if (n >= 3000) begin
        $display("Timeout: %0d packets still outstanding after drain", pending);
        timeouts++;
      end else begin
        if (got_cnt != exp_total) begin
          $display("ERR pkt_count exp %0d act %0d", exp_total, got_cnt);
          tb_err++;
        end
        @(negedge aclk);
        if (used !== 32'd0) begin
          $display("ERR used_drained exp 0 act %0d", used);
          tb_err++;
        end
      end
    end

    $display("Checker errors %0d, testbench errors %0d, timeouts %0d",
             err_cnt, tb_err, timeouts);
    if (err_cnt + tb_err + timeouts == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
+incdir+include
hdl/rdma_cmd_pkg.sv
hdl/rdma_pkt_pkg.sv
hdl/rdma_req_queue.sv
hdl/rdma_write_segmenter.sv
hdl/rdma_single_former.sv
hdl/rdma_req_parser.sv
hdl/rdma_req_top.sv
test/rdma_req_checker.sv
test/rdma_req_tb.sv
